/* sources.f */
+incdir+.
core_pkg.sv
issue_queue.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
core_top.sv
tb_core.sv

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: pc, instruction word, expected rd, expected value
// Illegal rows retire with value zero, write enable low
task automatic build_table();
    vec_count = 0;
    // ----------------------------------------------------------------------
    // Register setup
    // ----------------------------------------------------------------------
    add_vector(32'h2000, enc_u(20'h12345, 5'd1, OPC_LUI), 5'd1, 32'h1234_5000);
    add_vector(32'h2004, enc_i(12'h678, 5'd1, F3_ADD, 5'd1), 5'd1, 32'h1234_5678);
    add_vector(32'h2008, enc_i(12'hFFB, 5'd0, F3_ADD, 5'd2), 5'd2, 32'hFFFF_FFFB);
    add_vector(32'h200C, enc_i(12'h007, 5'd0, F3_ADD, 5'd3), 5'd3, 32'h0000_0007);
    // Register-register group
    add_vector(32'h2010, enc_r(7'h00, 5'd3, 5'd1, F3_ADD, 5'd4), 5'd4, 32'h1234_567F);
    add_vector(32'h2014, enc_r(7'h20, 5'd2, 5'd3, F3_ADD, 5'd5), 5'd5, 32'h0000_000C);
    add_vector(32'h2018, enc_r(7'h00, 5'd3, 5'd3, F3_SLL, 5'd6), 5'd6, 32'h0000_0380);
    add_vector(32'h201C, enc_r(7'h00, 5'd3, 5'd2, F3_SLT, 5'd7), 5'd7, 32'h0000_0001);
    add_vector(32'h2020, enc_r(7'h00, 5'd3, 5'd2, F3_SLTU, 5'd8), 5'd8, 32'h0000_0000);
    add_vector(32'h2024, enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd9), 5'd9, 32'hEDCB_A983);
    add_vector(32'h2028, enc_r(7'h00, 5'd3, 5'd2, F3_SR, 5'd10), 5'd10, 32'h01FF_FFFF);
    add_vector(32'h202C, enc_r(7'h20, 5'd3, 5'd2, F3_SR, 5'd11), 5'd11, 32'hFFFF_FFFF);
    add_vector(32'h2030, enc_r(7'h00, 5'd3, 5'd1, F3_OR, 5'd12), 5'd12, 32'h1234_567F);
    add_vector(32'h2034, enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd13), 5'd13, 32'h1234_5678);
    // Shift amount taken from the low five bits only
    add_vector(32'h2038, enc_i(12'h7E4, 5'd0, F3_ADD, 5'd14), 5'd14, 32'h0000_07E4);
    add_vector(32'h203C, enc_r(7'h00, 5'd14, 5'd3, F3_SLL, 5'd15), 5'd15, 32'h0000_0070);
    // ----------------------------------------------------------------------
    // Immediate group
    // ----------------------------------------------------------------------
    add_vector(32'h2040, enc_i(12'hFFC, 5'd2, F3_SLT, 5'd16), 5'd16, 32'h0000_0001);
    add_vector(32'h2044, enc_i(12'hFFF, 5'd3, F3_SLTU, 5'd17), 5'd17, 32'h0000_0001);
    add_vector(32'h2048, enc_i(12'hFFF, 5'd1, F3_XOR, 5'd18), 5'd18, 32'hEDCB_A987);
    add_vector(32'h204C, enc_i(12'h0F0, 5'd3, F3_OR, 5'd19), 5'd19, 32'h0000_00F7);
    add_vector(32'h2050, enc_i(12'h0FF, 5'd1, F3_AND, 5'd20), 5'd20, 32'h0000_0078);
    add_vector(32'h2054, enc_i(12'h004, 5'd1, F3_SLL, 5'd21), 5'd21, 32'h2345_6780);
    add_vector(32'h2058, enc_i(12'h01C, 5'd2, F3_SR, 5'd22), 5'd22, 32'h0000_000F);
    add_vector(32'h205C, enc_i(12'h401, 5'd2, F3_SR, 5'd23), 5'd23, 32'hFFFF_FFFD);
    add_vector(32'h2060, enc_i(12'h001, 5'd0, F3_SLTU, 5'd24), 5'd24, 32'h0000_0001);
    add_vector(32'h2064, enc_u(20'h00010, 5'd25, OPC_AUIPC), 5'd25, 32'h0001_2064);
    // Dependent chain at distances one, two and three
    add_vector(32'h2068, enc_i(12'h001, 5'd0, F3_ADD, 5'd26), 5'd26, 32'h0000_0001);
    add_vector(32'h206C, enc_i(12'h002, 5'd26, F3_ADD, 5'd26), 5'd26, 32'h0000_0003);
    add_vector(32'h2070, enc_r(7'h00, 5'd26, 5'd26, F3_ADD, 5'd27), 5'd27, 32'h0000_0006);
    add_vector(32'h2074, enc_r(7'h00, 5'd27, 5'd26, F3_ADD, 5'd28), 5'd28, 32'h0000_0009);
    add_vector(32'h2078, enc_r(7'h20, 5'd26, 5'd28, F3_ADD, 5'd29), 5'd29, 32'h0000_0006);
    // ----------------------------------------------------------------------
    // Illegal opcodes and x0
    // ----------------------------------------------------------------------
    add_vector(32'h207C, enc_i(12'h055, 5'd0, F3_ADD, 5'd30), 5'd30, 32'h0000_0055);
    add_illegal(32'h2080, {12'h000, 5'd0, 3'b010, 5'd30, 7'b0000011}, 5'd30);
    add_vector(32'h2084, enc_r(7'h00, 5'd0, 5'd30, F3_ADD, 5'd31), 5'd31, 32'h0000_0055);
    add_vector(32'h2088, enc_i(12'h123, 5'd1, F3_ADD, 5'd0), 5'd0, 32'h1234_579B);
    add_vector(32'h208C, enc_r(7'h00, 5'd0, 5'd0, F3_ADD, 5'd31), 5'd31, 32'h0000_0000);
    add_illegal(32'h2090, enc_r(7'h01, 5'd2, 5'd1, F3_ADD, 5'd5), 5'd5);
    add_vector(32'h2094, enc_i(12'h000, 5'd5, F3_ADD, 5'd6), 5'd6, 32'h0000_000C);
    add_vector(32'h2098, enc_u(20'hFFFFF, 5'd9, OPC_LUI), 5'd9, 32'hFFFF_F000);
    add_vector(32'h209C, enc_u(20'hFFFFF, 5'd10, OPC_AUIPC), 5'd10, 32'h0000_109C);
endtask

`endif

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module tb_core;
    import core_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int MAX_VECTORS = 48;

    logic      clk;
    logic      reset;
    logic      in_valid;
    instr_in_t in_instr;
    logic      ret_credit;
    logic      in_credit;
    logic      ret_valid;
    retire_t   ret_data;

    instr_in_t   vec_in  [MAX_VECTORS];
    retire_t     vec_exp [MAX_VECTORS];
    int          vec_count;
    logic        table_ready;
    logic [15:0] lfsr_state;
    // Upstream credits and retire credits not yet handed back
    int          tx_credits;
    int          held_credits;
    int          sent;
    int          retired;
    int          in_credit_pulses;

    core_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .ret_credit (ret_credit),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data)
    );

    // ----------------------------------------------------------------------
    // Instruction encoding and table fill
    // ----------------------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
        input opcode_e opc);
        return {imm, rd, opc};
    endfunction

    task automatic add_row(input logic [31:0] pc, input logic [31:0] word,
        input logic [4:0] rd, input logic [31:0] value, input logic illegal);
        vec_in[vec_count].pc       = pc;
        vec_in[vec_count].word     = word;
        vec_exp[vec_count].pc      = pc;
        vec_exp[vec_count].rd      = rd;
        vec_exp[vec_count].value   = value;
        vec_exp[vec_count].we      = !illegal;
        vec_exp[vec_count].illegal = illegal;
        vec_count++;
    endtask

    task automatic add_vector(input logic [31:0] pc, input logic [31:0] word,
        input logic [4:0] rd, input logic [31:0] value);
        add_row(pc, word, rd, value, 1'b0);
    endtask

    task automatic add_illegal(input logic [31:0] pc, input logic [31:0] word,
        input logic [4:0] rd);
        add_row(pc, word, rd, '0, 1'b1);
    endtask

    `include "tb_vectors.svh"

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_retire(input string name, input retire_t got, input retire_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic sample_outputs();
        if (in_credit)
        begin
            in_credit_pulses++;
            tx_credits++;
            if (tx_credits > `IQ_DEPTH)
            begin
                $display("More input credits returned than queue entries at %0t", $time);
                abort_run();
            end
        end
        if (ret_valid)
        begin
            if (retired >= vec_count)
            begin
                $display("A record retired after the whole table had retired at %0t", $time);
                abort_run();
            end
            compare_retire("ret_data", ret_data, vec_exp[retired]);
            retired++;
            held_credits++;
            if (held_credits > `RET_CREDITS)
            begin
                $display("More unreturned retires than retire credits at %0t", $time);
                abort_run();
            end
        end
    endtask

    task automatic drive_inputs();
        logic gap_a;
        logic gap_b;
        ret_credit = 1'b0;
        if ((held_credits > 0) && lfsr_bit())
        begin
            ret_credit = 1'b1;
            held_credits--;
        end
        in_valid = 1'b0;
        if ((sent < vec_count) && (tx_credits > 0))
        begin
            gap_a = lfsr_bit();
            gap_b = lfsr_bit();
            if (!(gap_a && gap_b))
            begin
                in_valid = 1'b1;
                in_instr = vec_in[sent];
                sent++;
                tx_credits--;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Clock, stimulus and watchdog
    // ----------------------------------------------------------------------
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_instr         = '0;
        ret_credit       = 1'b0;
        table_ready      = 1'b0;
        lfsr_state       = 16'd11;
        tx_credits       = `IQ_DEPTH;
        held_credits     = 0;
        sent             = 0;
        retired          = 0;
        in_credit_pulses = 0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (retired < vec_count)
        begin
            @(negedge clk);
            sample_outputs();
            drive_inputs();
        end
        // A few idle cycles catch any extra retire
        repeat (4)
        begin
            @(negedge clk);
            sample_outputs();
            drive_inputs();
        end
        compare_count("in_credit pulses", in_credit_pulses, sent);
        $display("TB PASSED");
        $finish;
    end

    initial
    begin
        wait (table_ready === 1'b1);
        repeat (vec_count * 40) @(posedge clk);
        $display("Timeout: retirement stalled after %0d of %0d records", retired, vec_count);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module core_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  core_pkg::instr_in_t in_instr,
    output logic                in_credit,
    input  logic                ret_credit,
    output logic                ret_valid,
    output core_pkg::retire_t   ret_data
);
    import core_pkg::*;

    logic                  issue_valid;
    instr_in_t             issue_instr;
    logic [`REG_IDX_W-1:0] rf_idx_a;
    logic [`REG_IDX_W-1:0] rf_idx_b;
    logic [`XLEN-1:0]      rf_data_a;
    logic [`XLEN-1:0]      rf_data_b;
    fwd_t                  ex_fwd;
    fwd_t                  res_fwd;
    logic                  ex_valid;
    exec_req_t             ex_req;
    logic                  res_valid;
    retire_t               res;
    logic                  wr_en;
    logic [`REG_IDX_W-1:0] wr_idx;
    logic [`XLEN-1:0]      wr_data;

    issue_queue issue_queue_i (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .ret_credit  (ret_credit),
        .in_credit   (in_credit),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .rf_idx_a    (rf_idx_a),
        .rf_idx_b    (rf_idx_b),
        .rf_data_a   (rf_data_a),
        .rf_data_b   (rf_data_b),
        .ex_fwd      (ex_fwd),
        .res_fwd     (res_fwd),
        .ex_valid    (ex_valid),
        .ex_req      (ex_req)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_req    (ex_req),
        .ex_fwd    (ex_fwd),
        .res_valid (res_valid),
        .res       (res)
    );

    result_stage result_stage_i (
        .res_valid (res_valid),
        .res       (res),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .res_fwd   (res_fwd),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    reg_file reg_file_i (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_a  (rf_idx_a),
        .rd_idx_b  (rf_idx_b),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

/* result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module result_stage (
    input  logic                  res_valid,
    input  core_pkg::retire_t     res,
    output logic                  wr_en,
    output logic [`REG_IDX_W-1:0] wr_idx,
    output logic [`XLEN-1:0]      wr_data,
    output core_pkg::fwd_t        res_fwd,
    output logic                  ret_valid,
    output core_pkg::retire_t     ret_data
);
    logic commit;

    // Writes to x0 and from illegal records are dropped here
    assign commit = res_valid && res.we && !res.illegal && (res.rd != '0);

    // ----------------------------------------------------------------------
    // Register-file write
    // ----------------------------------------------------------------------
    assign wr_en   = commit;
    assign wr_idx  = res.rd;
    assign wr_data = res.value;

    // Same value decode would read from the file one cycle later
    assign res_fwd.valid = commit;
    assign res_fwd.rd    = res.rd;
    assign res_fwd.value = res.value;

    // ----------------------------------------------------------------------
    // Retire port
    // ----------------------------------------------------------------------
    // One record per cycle in order, credit already reserved at issue
    assign ret_valid = res_valid;
    assign ret_data  = res;

    // Decode clears write enable for illegal opcodes and execute keeps it
    a_illegal_no_we: assert #0 (!(res_valid && res.illegal && res.we))
        else $error("result_stage: illegal record with write enable at pc %h", res.pc);

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  core_pkg::exec_req_t ex_req,
    output core_pkg::fwd_t      ex_fwd,
    output logic                res_valid,
    output core_pkg::retire_t   res
);
    import core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    assign op_a  = ex_req.operand_a;
    assign op_b  = ex_req.operand_b;
    assign shamt = op_b[4:0];

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (ex_req.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = `XLEN'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Result is visible to decode in the same cycle
    assign ex_fwd.valid = ex_valid && ex_req.we;
    assign ex_fwd.rd    = ex_req.rd;
    assign ex_fwd.value = alu_result;

    // ----------------------------------------------------------------------
    // Result-stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            res_valid <= 1'b0;
        else
            res_valid <= ex_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ex_valid)
        begin
            res.pc      <= ex_req.pc;
            res.rd      <= ex_req.rd;
            // Illegal instructions retire a zero value
            res.value   <= ex_req.illegal ? '0 : alu_result;
            res.we      <= ex_req.we;
            res.illegal <= ex_req.illegal;
        end
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  core_pkg::instr_in_t   issue_instr,
    output logic [`REG_IDX_W-1:0] rf_idx_a,
    output logic [`REG_IDX_W-1:0] rf_idx_b,
    input  logic [`XLEN-1:0]      rf_data_a,
    input  logic [`XLEN-1:0]      rf_data_b,
    input  core_pkg::fwd_t        ex_fwd,
    input  core_pkg::fwd_t        res_fwd,
    output logic                  ex_valid,
    output core_pkg::exec_req_t   ex_req
);
    import core_pkg::*;

    logic [`XLEN-1:0]      word;
    opcode_e               opcode;
    funct3_e               funct3;
    logic [6:0]            funct7;
    logic [`XLEN-1:0]      imm_i;
    logic [`XLEN-1:0]      imm_u;
    logic [`XLEN-1:0]      imm;
    logic [`XLEN-1:0]      src_a;
    logic [`XLEN-1:0]      src_b;
    alu_op_e               alu_op;
    logic                  use_pc;
    logic                  use_imm;
    logic                  illegal;
    exec_req_t             req_next;

    // Younger producer wins; x0 is never forwarded
    function automatic logic [`XLEN-1:0] pick_operand(
        input logic [`REG_IDX_W-1:0] idx,
        input logic [`XLEN-1:0]      rf_value,
        input fwd_t                  near,
        input fwd_t                  far
    );
        logic [`XLEN-1:0] value;
        value = rf_value;
        if ((idx != '0) && far.valid && (far.rd == idx))
            value = far.value;
        if ((idx != '0) && near.valid && (near.rd == idx))
            value = near.value;
        return value;
    endfunction

    // alt selects SUB or SRA
    function automatic alu_op_e base_op(input funct3_e f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Field split and immediates
    // ----------------------------------------------------------------------
    assign word     = issue_instr.word;
    assign opcode   = opcode_e'(word[6:0]);
    assign funct3   = funct3_e'(word[14:12]);
    assign funct7   = word[31:25];
    assign rf_idx_a = word[19:15];
    assign rf_idx_b = word[24:20];

    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_u = {word[31:12], 12'b0};

    always_comb
    begin
        alu_op  = ALU_ADD;
        use_pc  = 1'b0;
        use_imm = 1'b0;
        imm     = imm_i;
        illegal = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                alu_op  = base_op(funct3, funct7[5]);
                illegal = (funct7 != 7'b0000000) &&
                          !((funct7 == 7'b0100000) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
            end
            OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                // Upper immediate bits only mean SRAI for right shifts
                alu_op  = base_op(funct3, (funct3 == F3_SR) && funct7[5]);
                if (funct3 == F3_SLL)
                    illegal = (funct7 != 7'b0000000);
                if (funct3 == F3_SR)
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            OPC_LUI:
            begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            OPC_AUIPC:
            begin
                use_pc  = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: illegal = 1'b1;
        endcase
    end

    // ----------------------------------------------------------------------
    // Operand select and execute-stage register
    // ----------------------------------------------------------------------
    assign src_a = pick_operand(rf_idx_a, rf_data_a, ex_fwd, res_fwd);
    assign src_b = pick_operand(rf_idx_b, rf_data_b, ex_fwd, res_fwd);

    always_comb
    begin
        req_next.alu_op    = alu_op;
        req_next.operand_a = use_pc ? issue_instr.pc : src_a;
        req_next.operand_b = use_imm ? imm : src_b;
        req_next.rd        = word[11:7];
        req_next.we        = !illegal;
        req_next.illegal   = illegal;
        req_next.pc        = issue_instr.pc;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        if (issue_valid)
            ex_req <= req_next;
    end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rd_idx_a,
    input  logic [`REG_IDX_W-1:0] rd_idx_b,
    output logic [`XLEN-1:0]      rd_data_a,
    output logic [`XLEN-1:0]      rd_data_b,
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_idx,
    input  logic [`XLEN-1:0]      wr_data
);
    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_idx != '0))
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Asynchronous reads
    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

/* issue_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module issue_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  core_pkg::instr_in_t in_instr,
    input  logic                ret_credit,
    output logic                in_credit,
    output logic                issue_valid,
    output core_pkg::instr_in_t issue_instr
);
    import core_pkg::*;

    instr_in_t            entries [`IQ_DEPTH];
    logic [`IQ_PTR_W-1:0] head;
    logic [`IQ_PTR_W-1:0] tail;
    // Occupancy spans 0 to IQ_DEPTH, same range as the credit counter
    logic [`CREDIT_W-1:0] fill;
    logic [`CREDIT_W-1:0] credits;
    logic                 empty;
    logic                 full;
    logic                 pop;

    assign empty = (fill == '0);
    assign full  = (fill == `CREDIT_W'(`IQ_DEPTH));
    // Issue reserves one retire credit, so nothing downstream stalls
    assign pop   = !empty && (credits != '0);

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            entries[tail] <= in_instr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head <= '0;
            tail <= '0;
            fill <= '0;
        end
        else
        begin
            if (in_valid)
                tail <= tail + 1'b1;
            if (pop)
                head <= head + 1'b1;
            case ({in_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Retire credit counter
    always_ff @(posedge clk)
    begin
        if (reset)
            credits <= `CREDIT_W'(`RET_CREDITS);
        else
        begin
            case ({pop, ret_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= pop;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            issue_instr <= entries[head];
    end

    // The freed slot goes back upstream together with the issue
    assign in_credit = issue_valid;

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) in_valid |-> !full)
        else $error("issue_queue: write while queue is full");

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= `CREDIT_W'(`RET_CREDITS))
        else $error("issue_queue: retire credits above %0d", `RET_CREDITS);

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    // RV32I major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] word;
    } instr_in_t;

    // Operands are already resolved, PC and immediate included
    typedef struct packed {
        alu_op_e               alu_op;
        logic [`XLEN-1:0]      operand_a;
        logic [`XLEN-1:0]      operand_b;
        logic [`REG_IDX_W-1:0] rd;
        logic                  we;
        logic                  illegal;
        logic [`XLEN-1:0]      pc;
    } exec_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      value;
        logic                  we;
        logic                  illegal;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      value;
    } fwd_t;

endpackage

`default_nettype wire

/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ----------------------------------------------------------------------
// Datapath
// ----------------------------------------------------------------------
`define XLEN            32
`define REG_COUNT       32
`define REG_IDX_W       5

// ----------------------------------------------------------------------
// Issue queue and credits
// ----------------------------------------------------------------------
// Queue depth is also the upstream credit count after reset
`define IQ_DEPTH        4
`define IQ_PTR_W        2

// Retire credits held by the core after reset
`define RET_CREDITS     4
`define CREDIT_W        3

`endif
